// ==== Makefile ====
# Verilator simulation of the byte queue testbench

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module byte_queue_tb \
		-Mdir obj_dir -f byte_queue_top.f
	./obj_dir/Vbyte_queue_tb | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== byte_queue_top.f ====
common/axil_pkg.sv
common/queue_pkg.sv
fifo/fifo.sv
src/axil_capture.sv
src/queue_regs.sv
src/byte_queue_top.sv
test/clk_gen.sv
test/byte_queue_tb.sv

// ==== common/axil_pkg.sv ====
/* axil_pkg
   bus-side types for the AXI4-Lite register port: address, data, response code and transactions */
`default_nettype none

package axil_pkg;

   // the register map spans 16 bytes, so four address bits are enough
   localparam int ADDR_WIDTH = 4;
   localparam int DATA_WIDTH = 32;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [1:0]            resp_t;

   // standard AXI response encodings, EXOKAY is never produced by this slave
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;
   localparam resp_t RESP_DECERR = 2'b11;

   // one captured transaction as the register stage sees it
   // reads carry zero in the data field
   typedef struct packed {
      logic  write;
      addr_t addr;
      data_t data;
   } axil_req_t;

   // answer to one transaction, the data field only matters for reads
   typedef struct packed {
      data_t data;
      resp_t resp;
   } axil_resp_t;

endpackage

`default_nettype wire

// ==== common/queue_pkg.sv ====
/* queue_pkg
   queue-side constants and types: depth, entry width, fill count, register map, status bits */
`default_nettype none

package queue_pkg;

   localparam int QUEUE_DEPTH = 16;
   localparam int ITEM_WIDTH  = 8;

   // the count must reach QUEUE_DEPTH itself, hence the extra bit
   localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

   typedef logic [ITEM_WIDTH-1:0]  item_t;
   typedef logic [COUNT_WIDTH-1:0] count_t;

   // register offsets on the bus
   localparam axil_pkg::addr_t REG_DATA   = 4'h0;
   localparam axil_pkg::addr_t REG_STATUS = 4'h4;

   // STATUS layout
   // bits 4:0 hold the fill count, the flags sit in their own bytes
   localparam int STAT_EMPTY_BIT = 8;
   localparam int STAT_FULL_BIT  = 9;
   localparam int STAT_OVF_BIT   = 16;
   localparam int STAT_UNF_BIT   = 17;

endpackage

`default_nettype wire

// ==== fifo/fifo.sv ====
/* fifo
   show-ahead circular buffer with an occupancy counter, the oldest entry is always on head_data */
`timescale 1ns/1ps
`default_nettype none

module fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           push,
   input  wire  [WIDTH-1:0]              push_data,
   input  wire                           pop,
   output logic [WIDTH-1:0]              head_data,
   output logic                          full,
   output logic                          empty,
   output logic [$clog2(DEPTH + 1)-1:0]  count
);

   // a depth of one still needs a one-bit pointer
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count_q;

   // wraps at DEPTH-1 so that depths other than a power of two also work
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // storage array, written only on a push
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers and occupancy
   // the caller guarantees no push while full and no pop while empty
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // a push and a pop in the same cycle leave the count alone
         case ({push, pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   // show-ahead read port, no pop needed to see the head
   assign head_data = mem[rd_ptr];

   // flags follow the registered count, so they change on the same edge
   assign full  = (count_q == CNT_W'(DEPTH));
   assign empty = (count_q == '0);
   assign count = count_q;

endmodule

`default_nettype wire

// ==== src/axil_capture.sv ====
/* axil_capture
   AXI4-Lite front stage, takes one transaction at a time and holds its response until taken */
`timescale 1ns/1ps
`default_nettype none

module axil_capture (
   input  wire                        clk,
   input  wire                        rst_n,
   // write address channel
   input  wire axil_pkg::addr_t       awaddr,
   input  wire                        awvalid,
   output logic                       awready,
   // write data channel
   input  wire axil_pkg::data_t       wdata,
   input  wire                        wvalid,
   output logic                       wready,
   // write response channel
   output axil_pkg::resp_t            bresp,
   output logic                       bvalid,
   input  wire                        bready,
   // read address channel
   input  wire axil_pkg::addr_t       araddr,
   input  wire                        arvalid,
   output logic                       arready,
   // read data channel
   output axil_pkg::data_t            rdata,
   output axil_pkg::resp_t            rresp,
   output logic                       rvalid,
   input  wire                        rready,
   // towards the register stage
   output axil_pkg::axil_req_t        req,
   output logic                       req_valid,
   input  wire axil_pkg::axil_resp_t  resp,
   input  wire                        resp_valid
);

   import axil_pkg::*;

   // execute covers both the request cycle and the wait for the registered answer
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_RESP
   } state_t;

   state_t     state;
   axil_resp_t resp_q;
   logic       wr_accept;
   logic       rd_accept;
   logic       resp_taken;

   // the address and data channels of a write are opened together
   assign awready = (state == ST_IDLE);
   assign wready  = (state == ST_IDLE);

   // a half-presented write blocks reads, which is how writes win a tie
   assign arready = (state == ST_IDLE) && !awvalid && !wvalid;

   // a write needs both channels valid on the same edge
   assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
   assign rd_accept = arready && arvalid;

   // the stored write flag picks the channel that carries the answer
   assign bvalid = (state == ST_RESP) && req.write;
   assign rvalid = (state == ST_RESP) && !req.write;
   assign bresp  = resp_q.resp;
   assign rresp  = resp_q.resp;
   assign rdata  = resp_q.data;

   assign resp_taken = (bvalid && bready) || (rvalid && rready);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         req_valid <= 1'b0;
      end else begin
         // one-cycle pulse right after the accepting edge
         req_valid <= wr_accept || rd_accept;
         case (state)
            ST_IDLE: begin
               if (wr_accept || rd_accept) begin
                  state <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               if (resp_valid) begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               // stays here under back-pressure, nothing new gets in
               if (resp_taken) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // captured request, held for the whole transaction
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         req.write <= 1'b1;
         req.addr  <= awaddr;
         req.data  <= wdata;
      end else if (rd_accept) begin
         req.write <= 1'b0;
         req.addr  <= araddr;
         req.data  <= '0;
      end
   end

   // answer from the register stage, stable until the host takes it
   always_ff @(posedge clk) begin
      if (resp_valid && (state == ST_EXEC)) begin
         resp_q <= resp;
      end
   end

endmodule

`default_nettype wire

// ==== src/byte_queue_top.sv ====
/* byte_queue_top
   byte queue peripheral, an AXI4-Lite front stage over a register stage and a 16-entry FIFO */
`timescale 1ns/1ps
`default_nettype none

module byte_queue_top (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire axil_pkg::addr_t  awaddr,
   input  wire                   awvalid,
   output logic                  awready,
   input  wire axil_pkg::data_t  wdata,
   input  wire                   wvalid,
   output logic                  wready,
   output axil_pkg::resp_t       bresp,
   output logic                  bvalid,
   input  wire                   bready,
   input  wire axil_pkg::addr_t  araddr,
   input  wire                   arvalid,
   output logic                  arready,
   output axil_pkg::data_t       rdata,
   output axil_pkg::resp_t       rresp,
   output logic                  rvalid,
   input  wire                   rready
);

   import axil_pkg::*;
   import queue_pkg::*;

   // capture to register stage
   axil_req_t  req;
   logic       req_valid;
   axil_resp_t resp;
   logic       resp_valid;

   // register stage to FIFO
   logic   push;
   item_t  push_data;
   logic   pop;
   item_t  head_data;
   logic   full;
   logic   empty;
   count_t count;

   axil_capture u_capture (
      .clk        (clk),
      .rst_n      (rst_n),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .req        (req),
      .req_valid  (req_valid),
      .resp       (resp),
      .resp_valid (resp_valid)
   );

   queue_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .req_valid  (req_valid),
      .resp       (resp),
      .resp_valid (resp_valid),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .head_data  (head_data),
      .full       (full),
      .empty      (empty),
      .count      (count)
   );

   // sized from the queue constants, the FIFO itself is generic
   fifo #(
      .WIDTH (ITEM_WIDTH),
      .DEPTH (QUEUE_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head_data (head_data),
      .full      (full),
      .empty     (empty),
      .count     (count)
   );

endmodule

`default_nettype wire

// ==== src/queue_regs.sv ====
/* queue_regs
   register execute stage, decodes DATA and STATUS, drives the FIFO and keeps the sticky flags */
`timescale 1ns/1ps
`default_nettype none

module queue_regs (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire axil_pkg::axil_req_t   req,
   input  wire                        req_valid,
   output axil_pkg::axil_resp_t       resp,
   output logic                       resp_valid,
   output logic                       push,
   output queue_pkg::item_t           push_data,
   output logic                       pop,
   input  wire queue_pkg::item_t      head_data,
   input  wire                        full,
   input  wire                        empty,
   input  wire queue_pkg::count_t     count
);

   import axil_pkg::*;
   import queue_pkg::*;

   logic       is_data;
   logic       is_status;
   logic       wr_ovf;
   logic       rd_unf;
   logic       status_clr;
   logic       ovf_q;
   logic       unf_q;
   data_t      status_word;
   axil_resp_t resp_d;

   assign is_data   = (req.addr == REG_DATA);
   assign is_status = (req.addr == REG_STATUS);

   // the legality check lives only here, the FIFO trusts these strobes
   assign push = req_valid && req.write && is_data && !full;
   assign pop  = req_valid && !req.write && is_data && !empty;

   // only the low byte of a DATA write is queued
   assign push_data = req.data[ITEM_WIDTH-1:0];

   // a refused push or pop, reported as SLVERR and latched in a sticky flag
   assign wr_ovf = req_valid && req.write && is_data && full;
   assign rd_unf = req_valid && !req.write && is_data && empty;

   // write-one-to-clear on the sticky bits
   assign status_clr = req_valid && req.write && is_status;

   // STATUS image, count in the low bits and the flags above it
   always_comb begin
      status_word = '0;
      status_word[COUNT_WIDTH-1:0] = count;
      status_word[STAT_EMPTY_BIT]  = empty;
      status_word[STAT_FULL_BIT]   = full;
      status_word[STAT_OVF_BIT]    = ovf_q;
      status_word[STAT_UNF_BIT]    = unf_q;
   end

   // answer for the request currently presented
   // errors always come back with zero data
   always_comb begin
      resp_d.data = '0;
      resp_d.resp = RESP_OKAY;
      if (!is_data && !is_status) begin
         resp_d.resp = RESP_DECERR;
      end else if (wr_ovf || rd_unf) begin
         resp_d.resp = RESP_SLVERR;
      end else if (!req.write) begin
         // a DATA read returns the head, which leaves the FIFO on this same edge
         resp_d.data = is_data ? data_t'(head_data) : status_word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
         ovf_q      <= 1'b0;
         unf_q      <= 1'b0;
      end else begin
         resp_valid <= req_valid;
         if (wr_ovf) begin
            ovf_q <= 1'b1;
         end else if (status_clr && req.data[STAT_OVF_BIT]) begin
            ovf_q <= 1'b0;
         end
         if (rd_unf) begin
            unf_q <= 1'b1;
         end else if (status_clr && req.data[STAT_UNF_BIT]) begin
            unf_q <= 1'b0;
         end
      end
   end

   // registered answer, loaded once per request
   always_ff @(posedge clk) begin
      if (req_valid) begin
         resp <= resp_d;
      end
   end

endmodule

`default_nettype wire

// ==== test/byte_queue_tb.sv ====
/* byte_queue_tb
   byte queue testbench that drives the AXI4-Lite port and checks every response beat */
`timescale 1ns/1ps
`default_nettype none

module byte_queue_tb;

   import axil_pkg::*;
   import queue_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;

   // one predicted answer tagged with the channel it has to come back on
   typedef struct packed {
      logic       write;
      axil_resp_t resp;
   } expect_t;

   logic    clk;
   logic    rst_n;
   addr_t   awaddr;
   logic    awvalid;
   logic    awready;
   data_t   wdata;
   logic    wvalid;
   logic    wready;
   resp_t   bresp;
   logic    bvalid;
   logic    bready;
   addr_t   araddr;
   logic    arvalid;
   logic    arready;
   data_t   rdata;
   resp_t   rresp;
   logic    rvalid;
   logic    rready;

   // reference model of the queue and the two sticky flags
   item_t   model_q[$];
   logic    model_ovf;
   logic    model_unf;
   expect_t exp_q[$];

   logic [31:0] rng_state;
   string       cur_test;
   int          value_errs;
   int          proto_errs;
   int          beats;

   // state of the comparing process
   int          cycle_no;
   int          accept_cycle;
   logic        rise_pending;
   logic        held;
   logic        held_write;
   resp_t       held_resp;
   data_t       held_data;
   expect_t     want;

   clk_gen #(.PERIOD_NS(8)) u_clk (.clk(clk));

   byte_queue_top u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // predicts the answer to one transaction and moves the model on by the register rules
   function automatic axil_resp_t expect_resp(input logic write, input addr_t addr,
                                              input data_t data);
      axil_resp_t r;
      r.data = '0;
      r.resp = RESP_OKAY;
      if (addr == REG_DATA && write) begin
         // a push to a full queue is dropped
         if (model_q.size() == QUEUE_DEPTH) begin
            model_ovf = 1'b1;
            r.resp    = RESP_SLVERR;
         end else begin
            model_q.push_back(data[ITEM_WIDTH-1:0]);
         end
      end else if (addr == REG_DATA) begin
         // a pop from an empty queue returns zero
         if (model_q.size() == 0) begin
            model_unf = 1'b1;
            r.resp    = RESP_SLVERR;
         end else begin
            r.data = data_t'(model_q.pop_front());
         end
      end else if (addr == REG_STATUS && write) begin
         if (data[STAT_OVF_BIT]) begin
            model_ovf = 1'b0;
         end
         if (data[STAT_UNF_BIT]) begin
            model_unf = 1'b0;
         end
      end else if (addr == REG_STATUS) begin
         r.data[COUNT_WIDTH-1:0] = count_t'(model_q.size());
         r.data[STAT_EMPTY_BIT]  = (model_q.size() == 0);
         r.data[STAT_FULL_BIT]   = (model_q.size() == QUEUE_DEPTH);
         r.data[STAT_OVF_BIT]    = model_ovf;
         r.data[STAT_UNF_BIT]    = model_unf;
      end else begin
         r.resp = RESP_DECERR;
      end
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("timeout in %s: %s", cur_test, why);
      $display("** FAIL **");
      $finish;
   endtask

   // the address channel may lead the data channel by a few cycles
   task automatic present_write(input addr_t addr, input data_t data, input int gap);
      expect_t e;
      e.write = 1'b1;
      e.resp  = expect_resp(1'b1, addr, data);
      exp_q.push_back(e);
      @(negedge clk);
      awaddr  = addr;
      awvalid = 1'b1;
      repeat (gap) @(negedge clk);
      wdata  = data;
      wvalid = 1'b1;
   endtask

   task automatic present_read(input addr_t addr);
      expect_t e;
      e.write = 1'b0;
      e.resp  = expect_resp(1'b0, addr, '0);
      exp_q.push_back(e);
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
   endtask

   task automatic wait_write_accept();
      int t;
      t = 0;
      @(posedge clk);
      while (!(awready && wready)) begin
         t++;
         if (t > TIMEOUT_CYCLES) begin
            abort_run("write request was never accepted");
         end
         @(posedge clk);
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic wait_read_accept();
      int t;
      t = 0;
      @(posedge clk);
      while (!arready) begin
         t++;
         if (t > TIMEOUT_CYCLES) begin
            abort_run("read request was never accepted");
         end
         @(posedge clk);
      end
      @(negedge clk);
      arvalid = 1'b0;
   endtask

   task automatic wait_valid(input logic write);
      int t;
      t = 0;
      @(posedge clk);
      while (!(write ? bvalid : rvalid)) begin
         t++;
         if (t > TIMEOUT_CYCLES) begin
            abort_run("response valid never came");
         end
         @(posedge clk);
      end
   endtask

   // ready stays low for the given number of cycles, then takes one beat
   task automatic release_resp(input logic write, input int delay);
      repeat (delay + 1) @(negedge clk);
      if (write) begin
         bready = 1'b1;
      end else begin
         rready = 1'b1;
      end
      @(posedge clk);
      @(negedge clk);
      bready = 1'b0;
      rready = 1'b0;
   endtask

   task automatic do_write(input addr_t addr, input data_t data);
      present_write(addr, data, int'(next_random() % 32'd3));
      wait_write_accept();
      wait_valid(1'b1);
      release_resp(1'b1, int'(next_random() % 32'd4));
   endtask

   task automatic do_read(input addr_t addr);
      present_read(addr);
      wait_read_accept();
      wait_valid(1'b0);
      release_resp(1'b0, int'(next_random() % 32'd4));
   endtask

   task automatic drain_queue();
      while (model_q.size() > 0) begin
         do_read(REG_DATA);
      end
   endtask

   // compares every B and R beat and watches the handshake timing
   always @(posedge clk) begin
      if (rst_n) begin
         cycle_no++;
         if (u_dut.push && u_dut.full) begin
            proto_errs++;
            $display("%s: a push reached the FIFO while it was full", cur_test);
         end
         if (u_dut.pop && u_dut.empty) begin
            proto_errs++;
            $display("%s: a pop reached the FIFO while it was empty", cur_test);
         end
         // valid rises on the second edge after acceptance, so the third edge sees it first
         if (rise_pending && (bvalid || rvalid)) begin
            rise_pending = 1'b0;
            if (cycle_no != accept_cycle + 3) begin
               value_errs++;
               $display("FAILED %s: latency expected %0d actual %0d", cur_test, 2,
                        cycle_no - accept_cycle - 1);
            end
         end
         if (held) begin
            if ((held_write && !bvalid) || (!held_write && !rvalid)) begin
               proto_errs++;
               $display("%s: response valid dropped before it was taken", cur_test);
            end else if (((held_write ? bresp : rresp) != held_resp) ||
                         (!held_write && rdata != held_data)) begin
               proto_errs++;
               $display("%s: response changed while held under back-pressure", cur_test);
            end
         end
         if ((awvalid && awready && wvalid && wready) || (arvalid && arready)) begin
            if (bvalid || rvalid) begin
               proto_errs++;
               $display("%s: a request was accepted while a response was held", cur_test);
            end
            accept_cycle = cycle_no;
            rise_pending = 1'b1;
         end
         if ((bvalid && bready) || (rvalid && rready)) begin
            beats++;
            if (exp_q.size() == 0) begin
               proto_errs++;
               $display("%s: response beat with nothing outstanding", cur_test);
            end else begin
               want = exp_q.pop_front();
               if (want.write != bvalid) begin
                  proto_errs++;
                  $display("%s: response came back on the wrong channel", cur_test);
               end else if (bvalid) begin
                  if (bresp != want.resp.resp) begin
                     value_errs++;
                     $display("FAILED %s: bresp expected %0h actual %0h", cur_test,
                              want.resp.resp, bresp);
                  end
               end else begin
                  if (rresp != want.resp.resp) begin
                     value_errs++;
                     $display("FAILED %s: rresp expected %0h actual %0h", cur_test,
                              want.resp.resp, rresp);
                  end
                  if (rdata != want.resp.data) begin
                     value_errs++;
                     $display("FAILED %s: rdata expected %h actual %h", cur_test,
                              want.resp.data, rdata);
                  end
               end
            end
         end
         held       = (bvalid && !bready) || (rvalid && !rready);
         held_write = bvalid;
         held_resp  = bvalid ? bresp : rresp;
         held_data  = rdata;
      end
   end

   initial begin
      logic [31:0] r;
      data_t       sticky_bits;
      rng_state    = 32'h2f6d_83d3;
      model_ovf    = 1'b0;
      model_unf    = 1'b0;
      value_errs   = 0;
      proto_errs   = 0;
      beats        = 0;
      cycle_no     = 0;
      accept_cycle = 0;
      rise_pending = 1'b0;
      held         = 1'b0;
      cur_test     = "reset";
      sticky_bits  = (data_t'(1) << STAT_OVF_BIT) | (data_t'(1) << STAT_UNF_BIT);
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      rst_n   = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (!awready || !wready || !arready || bvalid || rvalid) begin
         proto_errs++;
         $display("reset: ready and valid outputs are not in their reset state");
      end

      // random mix of pushes and pops that keeps the queue between empty and full
      cur_test = "order";
      for (int i = 0; i < 80; i++) begin
         r = next_random();
         if (model_q.size() == 0 || (model_q.size() < QUEUE_DEPTH && r[0])) begin
            do_write(REG_DATA, data_t'(next_random()));
         end else begin
            do_read(REG_DATA);
         end
      end
      drain_queue();

      // the 17th push is refused and never read back
      cur_test = "overflow";
      for (int i = 0; i < QUEUE_DEPTH + 1; i++) begin
         do_write(REG_DATA, data_t'(next_random()));
      end
      do_read(REG_STATUS);
      drain_queue();

      cur_test = "underflow";
      do_read(REG_DATA);
      do_read(REG_STATUS);

      // both flags are still set here, so the decode test sees them unchanged
      // the decode writes carry both sticky bits so that a stray clear shows up in STATUS
      cur_test = "decode";
      do_write(REG_DATA, data_t'(next_random()));
      do_write(REG_DATA, data_t'(next_random()));
      do_write(4'h8, data_t'(next_random()) | sticky_bits);
      do_read(4'h8);
      do_write(4'hC, data_t'(next_random()) | sticky_bits);
      do_read(4'hC);
      do_read(REG_STATUS);

      cur_test = "flag_clear";
      do_write(REG_DATA, data_t'(next_random()));
      do_write(REG_STATUS, data_t'(1) << STAT_OVF_BIT);
      do_read(REG_STATUS);
      do_write(REG_STATUS, data_t'(1) << STAT_UNF_BIT);
      do_read(REG_STATUS);
      drain_queue();

      // a second request waits behind each held response
      cur_test = "backpressure";
      for (int i = 0; i < 6; i++) begin
         present_write(REG_DATA, data_t'(next_random()), 0);
         wait_write_accept();
         wait_valid(1'b1);
         present_read(REG_DATA);
         release_resp(1'b1, 2 + int'(next_random() % 32'd6));
         wait_read_accept();
         wait_valid(1'b0);
         present_write(REG_DATA, data_t'(next_random()), 1);
         release_resp(1'b0, 2 + int'(next_random() % 32'd6));
         wait_write_accept();
         wait_valid(1'b1);
         release_resp(1'b1, int'(next_random() % 32'd4));
      end
      drain_queue();

      repeat (3) @(negedge clk);
      if (exp_q.size() != 0) begin
         proto_errs++;
         $display("%0d predicted responses never arrived", exp_q.size());
      end
      $display("%0d beats checked, %0d value errors, %0d protocol errors", beats,
               value_errs, proto_errs);
      if (value_errs + proto_errs == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
/* clk_gen
   free-running testbench clock */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk
);

   // starts low, then toggles every half period
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire
